// File: all.f
design/gpu_config_pkg.sv
design/writeback_pkg.sv
design/wb_if.sv
design/writeback_arbiter.sv
design/gpr_file.sv
design/writeback_top.sv
testbench/tb_clock.sv
testbench/writeback_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and scans the log for failure.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module writeback_tb -f all.f -o writeback_sim \
	> build.log 2>&1 \
	|| { echo "Build failed, see build.log"; exit 1; }

./obj_dir/writeback_sim > sim.log 2>&1 \
	|| { echo "Simulation exited with an error, see sim.log"; exit 1; }

grep -q "=== FAIL ===" sim.log && { echo "Simulation failed, see sim.log"; exit 1; }
grep -q "=== PASS ===" sim.log && echo "Simulation passed" || { echo "No result in sim.log"; exit 1; }

// File: testbench/writeback_tb.sv
`timescale 1ns/1ps

module writeback_tb;
	import gpu_config_pkg::*;
	import writeback_pkg::*;

	localparam int num_threads = 4;
	localparam int num_warps = 4;
	localparam int warp_w = $clog2(num_warps);
	localparam int traffic_cycles = 600;
	localparam int total_cycles = 16 + traffic_cycles + 3 * num_warps * 32 + 60;

	typedef logic [num_threads-1:0] mask_t;
	typedef logic [warp_w-1:0] warp_t;
	typedef word_t [num_threads-1:0] lanes_t;

	typedef struct packed {
		mask_t valid;
		wb_kind_e kind;
		reg_addr_t rd;
		warp_t warp;
		pc_t pc;
		lanes_t data;
	} entry_t;

	logic clk;
	logic reset;
	mask_t exec_valid, csr_valid, mem_valid;
	wb_kind_e exec_kind, csr_kind, mem_kind;
	reg_addr_t exec_rd, csr_rd, mem_rd;
	warp_t exec_warp, csr_warp, mem_warp;
	pc_t exec_pc, mem_pc, scratch_pc;
	lanes_t exec_data, csr_data, mem_data;
	logic no_slot_mem, no_slot_csr;
	mask_t wb_valid;
	wb_kind_e wb_kind;
	reg_addr_t wb_rd;
	warp_t wb_warp;
	pc_t wb_pc;
	lanes_t wb_data;
	warp_t rd_warp;
	reg_addr_t rd_addr;
	lanes_t rd_data;

	word_t model_regs [num_warps][32][num_threads];
	entry_t exp_q [$];
	logic [15:0] lfsr_state = 16'd59920;
	int test_checks = 0;
	int test_errors = 0;
	int total_checks = 0;
	int total_errors = 0;
	int held_mem_writes = 0;

	tb_clock clock_gen (.clk(clk));

	writeback_top #(.num_threads(num_threads), .num_warps(num_warps)) dut_i (
		.clk(clk), .reset(reset),
		.exec_valid(exec_valid), .exec_kind(exec_kind), .exec_rd(exec_rd),
		.exec_warp(exec_warp), .exec_pc(exec_pc), .exec_data(exec_data),
		.csr_valid(csr_valid), .csr_kind(csr_kind), .csr_rd(csr_rd),
		.csr_warp(csr_warp), .csr_data(csr_data),
		.mem_valid(mem_valid), .mem_kind(mem_kind), .mem_rd(mem_rd),
		.mem_warp(mem_warp), .mem_pc(mem_pc), .mem_data(mem_data),
		.no_slot_mem(no_slot_mem), .no_slot_csr(no_slot_csr),
		.wb_valid(wb_valid), .wb_kind(wb_kind), .wb_rd(wb_rd),
		.wb_warp(wb_warp), .wb_pc(wb_pc), .wb_data(wb_data),
		.rd_warp(rd_warp), .rd_addr(rd_addr), .rd_data(rd_data)
	);

	// Fibonacci LFSR with taps 16 14 13 11 and one step per bit.
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		logic fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
			lfsr_state = {lfsr_state[14:0], fb};
			v = {v[30:0], fb};
		end
		return v;
	endfunction

	function automatic logic requests(input mask_t v, input wb_kind_e k);
		return (k != wb_none) && (v != '0);
	endfunction

	// Expected register contents for the inputs now driven.
	function automatic entry_t expected_winner();
		entry_t e;
		e = '0;
		e.kind = wb_none;
		if (requests(exec_valid, exec_kind)) begin
			e = {exec_valid, exec_kind, exec_rd, exec_warp, exec_pc, exec_data};
		end else if (requests(csr_valid, csr_kind)) begin
			e = {csr_valid, csr_kind, csr_rd, csr_warp, csr_pc, csr_data};
		end else if (requests(mem_valid, mem_kind)) begin
			e = {mem_valid, mem_kind, mem_rd, mem_warp, mem_pc, mem_data};
		end
		return e;
	endfunction

	task automatic check_word(input string name, input word_t exp, input word_t act);
		test_checks++;
		if (exp !== act) begin
			test_errors++;
			$display("[ERROR] %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_addr(input string name, input reg_addr_t exp, input reg_addr_t act);
		test_checks++;
		if (exp !== act) begin
			test_errors++;
			$display("[ERROR] %s: expected %0d, actual %0d", name, exp, act);
		end
	endtask

	task automatic check_kind(input string name, input wb_kind_e exp, input wb_kind_e act);
		test_checks++;
		if (exp !== act) begin
			test_errors++;
			$display("[ERROR] %s: expected %s, actual %s", name, exp.name(), act.name());
		end
	endtask

	task automatic check_mask(input string name, input mask_t exp, input mask_t act);
		test_checks++;
		if (exp !== act) begin
			test_errors++;
			$display("[ERROR] %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		test_checks++;
		if (exp !== act) begin
			test_errors++;
			$display("[ERROR] %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	task automatic finish_test(input string name);
		$display("%-18s %0d checks, %0d errors", name, test_checks, test_errors);
		total_checks += test_checks;
		total_errors += test_errors;
		test_checks = 0;
		test_errors = 0;
	endtask

	task automatic drive_idle();
		{exec_valid, exec_rd, exec_warp, exec_pc, exec_data} = '0;
		{csr_valid, csr_rd, csr_warp, csr_data} = '0;
		{mem_valid, mem_rd, mem_warp, mem_pc, mem_data} = '0;
		exec_kind = wb_none;
		csr_kind = wb_none;
		mem_kind = wb_none;
	endtask

	// Half the time a real request, otherwise kind wb_none with a random mask.
	task automatic random_stream(output mask_t v, output wb_kind_e k, output reg_addr_t r,
			output warp_t w, output pc_t p, output lanes_t d);
		logic [31:0] bits;
		logic req;
		req = rand_bits(1) != 0;
		bits = rand_bits(num_threads);
		v = bits[num_threads-1:0];
		bits = rand_bits(2);
		k = wb_kind_e'(bits[1:0]);
		if (req && k == wb_none) k = wb_alu;
		if (req && v == '0) v = mask_t'(1);
		if (!req) k = wb_none;
		bits = rand_bits(5);
		r = bits[4:0];
		bits = rand_bits(warp_w);
		w = bits[warp_w-1:0];
		p = rand_bits(32);
		for (int t = 0; t < num_threads; t++) d[t] = rand_bits(32);
	endtask

	// Checks the registered output and applies it to the model register file.
	task automatic compare_pending();
		entry_t e;
		if (exp_q.size() > 0) begin
			e = exp_q.pop_front();
			check_mask("wb_valid", e.valid, wb_valid);
			check_kind("wb_kind", e.kind, wb_kind);
			check_addr("wb_rd", e.rd, wb_rd);
			check_addr("wb_warp", reg_addr_t'(e.warp), reg_addr_t'(wb_warp));
			check_word("wb_pc", e.pc, wb_pc);
			for (int t = 0; t < num_threads; t++) begin
				check_word($sformatf("wb_data[%0d]", t), e.data[t], wb_data[t]);
				if (requests(e.valid, e.kind) && e.rd != 0 && e.valid[t])
					model_regs[e.warp][e.rd][t] = e.data[t];
			end
		end
	endtask

	task automatic read_all();
		for (int w = 0; w < num_warps; w++) begin
			for (int r = 0; r < 32; r++) begin
				@(negedge clk);
				rd_warp = warp_t'(w);
				rd_addr = reg_addr_t'(r);
				#1;
				for (int t = 0; t < num_threads; t++)
					check_word($sformatf("w%0d r%0d t%0d", w, r, t),
						model_regs[w][r][t], rd_data[t]);
			end
		end
	endtask

	initial begin
		#(total_cycles * 10 + 500);
		$display("Timeout: the run did not finish in the expected number of cycles");
		$display("=== FAIL ===");
		$finish;
	end

	initial begin
		logic mem_held;
		logic csr_held;
		logic exec_req;
		logic csr_req;
		logic mem_req;
		drive_idle();
		reset = 1'b1;
		rd_warp = '0;
		rd_addr = '0;
		scratch_pc = '0;
		mem_held = 1'b0;
		csr_held = 1'b0;
		for (int w = 0; w < num_warps; w++)
			for (int r = 0; r < 32; r++)
				for (int t = 0; t < num_threads; t++)
					model_regs[w][r][t] = '0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		@(negedge clk);
		check_mask("wb_valid after reset", '0, wb_valid);
		check_kind("wb_kind after reset", wb_none, wb_kind);
		read_all();
		finish_test("reset_state");

		repeat (traffic_cycles) begin
			@(negedge clk);
			compare_pending();
			random_stream(exec_valid, exec_kind, exec_rd, exec_warp, exec_pc, exec_data);
			if (!csr_held)
				random_stream(csr_valid, csr_kind, csr_rd, csr_warp, scratch_pc, csr_data);
			if (!mem_held)
				random_stream(mem_valid, mem_kind, mem_rd, mem_warp, mem_pc, mem_data);
			#1;
			exec_req = requests(exec_valid, exec_kind);
			csr_req = requests(csr_valid, csr_kind);
			mem_req = requests(mem_valid, mem_kind);
			check_flag("no_slot_mem", mem_req && (exec_req || csr_req), no_slot_mem);
			check_flag("no_slot_csr", csr_req && exec_req, no_slot_csr);
			if (mem_held && mem_req && !exec_req && !csr_req) held_mem_writes++;
			mem_held = mem_req && (exec_req || csr_req);
			csr_held = csr_req && exec_req;
			exp_q.push_back(expected_winner());
		end
		@(negedge clk);
		compare_pending();
		drive_idle();
		test_checks++;
		if (held_mem_writes == 0) begin
			test_errors++;
			$display("No held memory request was ever written back");
		end
		finish_test("random_traffic");

		repeat (2) @(negedge clk);
		read_all();
		finish_test("register_readback");

		// Each source in turn targets register 0 in every lane.
		for (int s = 0; s < 3; s++) begin
			@(negedge clk);
			compare_pending();
			drive_idle();
			if (s == 0) begin
				exec_valid = '1;
				exec_kind = wb_alu;
				exec_data = '1;
			end
			if (s == 1) begin
				csr_valid = '1;
				csr_kind = wb_alu;
				csr_data = '1;
			end
			if (s == 2) begin
				mem_valid = '1;
				mem_kind = wb_mem;
				mem_data = '1;
			end
			#1;
			exp_q.push_back(expected_winner());
		end
		@(negedge clk);
		compare_pending();
		drive_idle();
		repeat (2) @(negedge clk);
		for (int w = 0; w < num_warps; w++) begin
			@(negedge clk);
			rd_warp = warp_t'(w);
			rd_addr = '0;
			#1;
			for (int t = 0; t < num_threads; t++)
				check_word($sformatf("w%0d r0 t%0d", w, t), '0, rd_data[t]);
		end
		finish_test("register_zero");

		$display("Total: %0d checks, %0d errors, %0d held memory writes",
			total_checks, total_errors, held_mem_writes);
		if (total_errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

// File: testbench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
	output logic clk
);

	// 10 ns period.
	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

endmodule

// File: design/writeback_top.sv
`timescale 1ns/1ps

module writeback_top #(
	parameter int num_threads = gpu_config_pkg::default_num_threads,
	parameter int num_warps = gpu_config_pkg::default_num_warps
) (
	input logic clk,
	input logic reset,

	input logic [num_threads-1:0] exec_valid,
	input writeback_pkg::wb_kind_e exec_kind,
	input gpu_config_pkg::reg_addr_t exec_rd,
	input logic [$clog2(num_warps)-1:0] exec_warp,
	input gpu_config_pkg::pc_t exec_pc,
	input gpu_config_pkg::word_t [num_threads-1:0] exec_data,

	input logic [num_threads-1:0] csr_valid,
	input writeback_pkg::wb_kind_e csr_kind,
	input gpu_config_pkg::reg_addr_t csr_rd,
	input logic [$clog2(num_warps)-1:0] csr_warp,
	input gpu_config_pkg::word_t [num_threads-1:0] csr_data,

	input logic [num_threads-1:0] mem_valid,
	input writeback_pkg::wb_kind_e mem_kind,
	input gpu_config_pkg::reg_addr_t mem_rd,
	input logic [$clog2(num_warps)-1:0] mem_warp,
	input gpu_config_pkg::pc_t mem_pc,
	input gpu_config_pkg::word_t [num_threads-1:0] mem_data,

	output logic no_slot_mem,
	output logic no_slot_csr,

	output logic [num_threads-1:0] wb_valid,
	output writeback_pkg::wb_kind_e wb_kind,
	output gpu_config_pkg::reg_addr_t wb_rd,
	output logic [$clog2(num_warps)-1:0] wb_warp,
	output gpu_config_pkg::pc_t wb_pc,
	output gpu_config_pkg::word_t [num_threads-1:0] wb_data,

	input logic [$clog2(num_warps)-1:0] rd_warp,
	input gpu_config_pkg::reg_addr_t rd_addr,
	output gpu_config_pkg::word_t [num_threads-1:0] rd_data
);

	wb_if #(.num_threads(num_threads), .num_warps(num_warps)) exec_wb ();
	wb_if #(.num_threads(num_threads), .num_warps(num_warps)) csr_wb ();
	wb_if #(.num_threads(num_threads), .num_warps(num_warps)) mem_wb ();
	wb_if #(.num_threads(num_threads), .num_warps(num_warps)) gpr_wb ();

	assign exec_wb.valid = exec_valid;
	assign exec_wb.kind = exec_kind;
	assign exec_wb.rd = exec_rd;
	assign exec_wb.warp = exec_warp;
	assign exec_wb.pc = exec_pc;
	assign exec_wb.data = exec_data;

	// The CSR stream carries no PC.
	assign csr_wb.valid = csr_valid;
	assign csr_wb.kind = csr_kind;
	assign csr_wb.rd = csr_rd;
	assign csr_wb.warp = csr_warp;
	assign csr_wb.pc = '0;
	assign csr_wb.data = csr_data;

	assign mem_wb.valid = mem_valid;
	assign mem_wb.kind = mem_kind;
	assign mem_wb.rd = mem_rd;
	assign mem_wb.warp = mem_warp;
	assign mem_wb.pc = mem_pc;
	assign mem_wb.data = mem_data;

	writeback_arbiter #(.num_threads(num_threads), .num_warps(num_warps)) arbiter (
		.clk(clk),
		.reset(reset),
		.exec_wb(exec_wb.sink),
		.csr_wb(csr_wb.sink),
		.mem_wb(mem_wb.sink),
		.gpr_wb(gpr_wb.source),
		.no_slot_mem(no_slot_mem),
		.no_slot_csr(no_slot_csr)
	);

	gpr_file #(.num_threads(num_threads), .num_warps(num_warps)) gpr (
		.clk(clk),
		.reset(reset),
		.wb(gpr_wb.sink),
		.rd_warp(rd_warp),
		.rd_addr(rd_addr),
		.rd_data(rd_data)
	);

	assign wb_valid = gpr_wb.valid;
	assign wb_kind = gpr_wb.kind;
	assign wb_rd = gpr_wb.rd;
	assign wb_warp = gpr_wb.warp;
	assign wb_pc = gpr_wb.pc;
	assign wb_data = gpr_wb.data;

endmodule

// File: design/gpr_file.sv
`timescale 1ns/1ps

module gpr_file #(
	parameter int num_threads = gpu_config_pkg::default_num_threads,
	parameter int num_warps = gpu_config_pkg::default_num_warps
) (
	input logic clk,
	input logic reset,
	wb_if.sink wb,
	input logic [$clog2(num_warps)-1:0] rd_warp,
	input gpu_config_pkg::reg_addr_t rd_addr,
	output gpu_config_pkg::word_t [num_threads-1:0] rd_data
);
	import gpu_config_pkg::*;
	import writeback_pkg::*;

	localparam int num_regs = 2 ** $bits(reg_addr_t);

	word_t regs [num_warps][num_regs][num_threads];
	logic wr_en;

	// Register 0 is never written.
	assign wr_en = (wb.kind != wb_none) && (|wb.valid) && (wb.rd != '0);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int w = 0; w < num_warps; w++) begin
				for (int r = 0; r < num_regs; r++) begin
					for (int t = 0; t < num_threads; t++) begin
						regs[w][r][t] <= '0;
					end
				end
			end
		end else if (wr_en) begin
			// Only the lanes marked valid take the new word.
			for (int t = 0; t < num_threads; t++) begin
				if (wb.valid[t]) begin
					regs[wb.warp][wb.rd][t] <= wb.data[t];
				end
			end
		end
	end

	always_comb begin
		for (int t = 0; t < num_threads; t++) begin
			if (rd_addr == '0) begin
				rd_data[t] = '0;
			end else begin
				rd_data[t] = regs[rd_warp][rd_addr][t];
			end
		end
	end

endmodule

// File: design/writeback_arbiter.sv
`timescale 1ns/1ps

module writeback_arbiter #(
	parameter int num_threads = gpu_config_pkg::default_num_threads,
	parameter int num_warps = gpu_config_pkg::default_num_warps
) (
	input logic clk,
	input logic reset,
	wb_if.sink exec_wb,
	wb_if.sink csr_wb,
	wb_if.sink mem_wb,
	wb_if.source gpr_wb,
	output logic no_slot_mem,
	output logic no_slot_csr
);
	import gpu_config_pkg::*;
	import writeback_pkg::*;

	localparam int warp_w = $clog2(num_warps);

	logic exec_req;
	logic csr_req;
	logic mem_req;
	wb_source_e sel;

	logic [num_threads-1:0] sel_valid;
	wb_kind_e sel_kind;
	reg_addr_t sel_rd;
	logic [warp_w-1:0] sel_warp;
	pc_t sel_pc;
	word_t [num_threads-1:0] sel_data;

	// A stream asks for a slot when it has a real kind and a live lane.
	assign exec_req = (exec_wb.kind != wb_none) && (|exec_wb.valid);
	assign csr_req = (csr_wb.kind != wb_none) && (|csr_wb.valid);
	assign mem_req = (mem_wb.kind != wb_none) && (|mem_wb.valid);

	assign no_slot_mem = mem_req && (exec_req || csr_req);
	assign no_slot_csr = csr_req && exec_req;

	// Fixed priority with execute first and memory last.
	always_comb begin
		if (exec_req) begin
			sel = src_exec;
		end else if (csr_req) begin
			sel = src_csr;
		end else if (mem_req) begin
			sel = src_mem;
		end else begin
			sel = src_none;
		end
	end

	always_comb begin
		sel_valid = '0;
		sel_kind = wb_none;
		sel_rd = '0;
		sel_warp = '0;
		sel_pc = '0;
		sel_data = '0;
		case (sel)
			src_exec: begin
				sel_valid = exec_wb.valid;
				sel_kind = exec_wb.kind;
				sel_rd = exec_wb.rd;
				sel_warp = exec_wb.warp;
				sel_pc = exec_wb.pc;
				sel_data = exec_wb.data;
			end
			src_csr: begin
				sel_valid = csr_wb.valid;
				sel_kind = csr_wb.kind;
				sel_rd = csr_wb.rd;
				sel_warp = csr_wb.warp;
				sel_pc = csr_pc;
				sel_data = csr_wb.data;
			end
			src_mem: begin
				sel_valid = mem_wb.valid;
				sel_kind = mem_wb.kind;
				sel_rd = mem_wb.rd;
				sel_warp = mem_wb.warp;
				sel_pc = mem_wb.pc;
				sel_data = mem_wb.data;
			end
			default: begin
			end
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			gpr_wb.valid <= '0;
			gpr_wb.kind <= wb_none;
		end else begin
			gpr_wb.valid <= sel_valid;
			gpr_wb.kind <= sel_kind;
		end
	end

	// Payload of the selected stream.
	always_ff @(posedge clk) begin
		gpr_wb.rd <= sel_rd;
		gpr_wb.warp <= sel_warp;
		gpr_wb.pc <= sel_pc;
		gpr_wb.data <= sel_data;
	end

endmodule

// File: design/wb_if.sv
`timescale 1ns/1ps

interface wb_if #(
	parameter int num_threads = gpu_config_pkg::default_num_threads,
	parameter int num_warps = gpu_config_pkg::default_num_warps
);
	import gpu_config_pkg::*;
	import writeback_pkg::*;

	localparam int warp_w = $clog2(num_warps);

	// Per-thread lane mask.
	logic [num_threads-1:0] valid;
	wb_kind_e kind;
	reg_addr_t rd;
	logic [warp_w-1:0] warp;
	pc_t pc;
	word_t [num_threads-1:0] data;

	modport source (
		output valid,
		output kind,
		output rd,
		output warp,
		output pc,
		output data
	);

	modport sink (
		input valid,
		input kind,
		input rd,
		input warp,
		input pc,
		input data
	);

endinterface

// File: design/writeback_pkg.sv
package writeback_pkg;

	// Kind of result being written back. Only wb_none means no write.
	typedef enum logic [1:0] {
		wb_none    = 2'd0,
		wb_alu     = 2'd1,
		wb_mem     = 2'd2,
		wb_pc_next = 2'd3
	} wb_kind_e;

	// Source chosen by the arbiter in a given cycle.
	typedef enum logic [1:0] {
		src_none = 2'd0,
		src_exec = 2'd1,
		src_csr  = 2'd2,
		src_mem  = 2'd3
	} wb_source_e;

	// The CSR unit reports no PC, so writeback shows this marker instead.
	localparam gpu_config_pkg::pc_t csr_pc = 32'hdeadbeef;

endpackage

// File: design/gpu_config_pkg.sv
package gpu_config_pkg;

	// One thread's data word.
	typedef logic [31:0] word_t;

	// Program counter.
	typedef logic [31:0] pc_t;

	// Index into the 32 architectural registers.
	typedef logic [4:0] reg_addr_t;

	// Core shape used when the top level is not overridden.
	localparam int default_num_threads = 4;
	localparam int default_num_warps = 4;

endpackage
